/* src/cpuPkg.sv */
////////////////////////////////////////////////////////////////////////////
// shared types for the 8-bit 6502-class arithmetic datapath
// all widths are fixed at one byte
// the control word is taken every phi2 cycle, there is no stall path
// status bit 4 always reads 0 and bit 5 always reads 1
////////////////////////////////////////////////////////////////////////////
package cpuPkg;

    localparam int dataWidth = 8;

    typedef logic [dataWidth-1:0] byte_t;

    // operand A comes from one architectural register or zero
    typedef enum logic [2:0] {
        srcAcc  = 3'd0,
        srcX    = 3'd1,
        srcY    = 3'd2,
        srcSp   = 3'd3,
        srcZero = 3'd4
    } aSrc_e;

    typedef enum logic {
        bData = 1'b0,
        bZero = 1'b1
    } bSrc_e;

    typedef enum logic [1:0] {
        cinZero  = 2'd0,
        cinOne   = 2'd1,
        cinCarry = 2'd2
    } cinSel_e;

    typedef enum logic [2:0] {
        opAdd = 3'd0,
        opSub = 3'd1,
        opAnd = 3'd2,
        opEor = 3'd3,
        opOr  = 3'd4,
        opShr = 3'd5
    } aluOp_e;

    typedef enum logic [2:0] {
        flagKeep   = 3'd0,
        flagNz     = 3'd1,
        flagNzc    = 3'd2,
        flagNzcv   = 3'd3,
        flagLoad   = 3'd4,
        flagSetClr = 3'd5
    } flagMode_e;

    typedef struct packed {
        logic setC;
        logic clrC;
        logic setI;
        logic clrI;
        logic setD;
        logic clrD;
        logic clrV;
    } setClr_t;

    typedef struct packed {
        logic wrAcc;
        logic wrX;
        logic wrY;
        logic wrSp;
    } destMask_t;

    typedef struct packed {
        logic      valid;
        aSrc_e     aSel;
        bSrc_e     bSel;
        cinSel_e   cinSel;
        aluOp_e    aluOp;
        destMask_t dest;
        flagMode_e flagMode;
        setClr_t   setClr;
    } ctrlWord_t;

    // second pipeline stage, data rides along for flagLoad
    typedef struct packed {
        logic      valid;
        aluOp_e    aluOp;
        byte_t     result;
        logic      acr;
        logic      avr;
        logic      hc;
        destMask_t dest;
        flagMode_e flagMode;
        setClr_t   setClr;
        byte_t     data;
    } holdReg_t;

    typedef struct packed {
        byte_t acc;
        byte_t x;
        byte_t y;
        byte_t sp;
    } regFile_t;

    typedef struct packed {
        byte_t acc;
        byte_t x;
        byte_t y;
        byte_t sp;
        byte_t status;
    } archState_t;

    // status layout NV-BDIZC
    localparam int statusC = 0;
    localparam int statusZ = 1;
    localparam int statusI = 2;
    localparam int statusD = 3;
    localparam int statusB = 4;
    localparam int statusV = 6;
    localparam int statusN = 7;

    localparam byte_t statusReset = 8'h20;

endpackage

/* src/registerFile.sv */
////////////////////////////////////////////////////////////////////////////
// accumulator, X, Y and stack pointer
// operand A is combinational from the current register values, so an
// operation issued right after a writer still sees the old value
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module registerFile
    import cpuPkg::*;
(
    input  logic     phi2,
    input  logic     rstAll,
    input  aSrc_e    aSel,
    input  holdReg_t hold,
    input  byte_t    wbData,
    output byte_t    operandA,
    output regFile_t regs
);

    byte_t acc;
    byte_t xReg;
    byte_t yReg;
    byte_t sp;

    // operand A select, replaces the SB bus drivers
    always_comb begin
        case (aSel)
            srcAcc:  operandA = acc;
            srcX:    operandA = xReg;
            srcY:    operandA = yReg;
            srcSp:   operandA = sp;
            default: operandA = '0;
        endcase
    end

    // writeback from the hold stage, one enable per register
    always_ff @(posedge phi2 or posedge rstAll) begin
        if (rstAll) begin
            acc  <= '0;
            xReg <= '0;
            yReg <= '0;
            sp   <= '0;
        end else if (hold.valid) begin
            if (hold.dest.wrAcc)
                acc <= wbData;
            if (hold.dest.wrX)
                xReg <= wbData;
            if (hold.dest.wrY)
                yReg <= wbData;
            if (hold.dest.wrSp)
                sp <= wbData;
        end
    end

    assign regs.acc = acc;
    assign regs.x   = xReg;
    assign regs.y   = yReg;
    assign regs.sp  = sp;

endmodule

/* src/aluStage.sv */
////////////////////////////////////////////////////////////////////////////
// first pipeline stage: operand B and carry-in select, ALU and the adder
// hold register, which loads on every phi2 edge
// subtract inverts B here, so callers issue it with carry-in set for a
// borrow-free difference
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module aluStage
    import cpuPkg::*;
(
    input  logic      phi2,
    input  logic      rstAll,
    input  ctrlWord_t ctrl,
    input  byte_t     operandA,
    input  byte_t     dataIn,
    input  logic      carryFlag,
    output holdReg_t  hold
);

    byte_t      opB;
    logic       cin;
    logic [8:0] sum;
    logic [4:0] halfSum;
    byte_t      aluOut;
    logic       acrNext;
    logic       avrNext;
    logic       hcNext;

    // B input, inverted for subtract like the DB_L_AD path
    always_comb begin
        opB = (ctrl.bSel == bData) ? dataIn : '0;
        if (ctrl.aluOp == opSub)
            opB = ~opB;
    end

    always_comb begin
        case (ctrl.cinSel)
            cinOne:   cin = 1'b1;
            cinCarry: cin = carryFlag;
            default:  cin = 1'b0;
        endcase
    end

    assign sum     = {1'b0, operandA} + {1'b0, opB} + {8'b0, cin};
    assign halfSum = {1'b0, operandA[3:0]} + {1'b0, opB[3:0]} + {4'b0, cin};

    always_comb begin
        acrNext = 1'b0;
        avrNext = 1'b0;
        hcNext  = 1'b0;
        case (ctrl.aluOp)
            opAdd, opSub: begin
                aluOut  = sum[dataWidth-1:0];
                acrNext = sum[dataWidth];
                hcNext  = halfSum[4];
                // overflow when both signs agree and the result sign flips
                avrNext = (operandA[7] == opB[7]) && (sum[7] != operandA[7]);
            end
            opAnd:   aluOut = operandA & opB;
            opEor:   aluOut = operandA ^ opB;
            opOr:    aluOut = operandA | opB;
            opShr: begin
                aluOut  = {cin, opB[7:1]};
                acrNext = opB[0];
            end
            default: aluOut = '0;
        endcase
    end

    always_ff @(posedge phi2 or posedge rstAll) begin
        if (rstAll) begin
            hold <= '0;
        end else begin
            hold.valid    <= ctrl.valid;
            hold.aluOp    <= ctrl.aluOp;
            hold.result   <= aluOut;
            hold.acr      <= acrNext;
            hold.avr      <= avrNext;
            hold.hc       <= hcNext;
            hold.dest     <= ctrl.dest;
            hold.flagMode <= ctrl.flagMode;
            hold.setClr   <= ctrl.setClr;
            hold.data     <= dataIn;
        end
    end

endmodule

/* src/decimalAdjust.sv */
////////////////////////////////////////////////////////////////////////////
// BCD correction of the held sum, combinational
// only meaningful when both operands were valid BCD
// the D flag is taken from the committed status, not from the hold stage
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module decimalAdjust
    import cpuPkg::*;
(
    input  holdReg_t hold,
    input  logic     decimalFlag,
    output byte_t    wbData,
    output logic     decCarry
);

    logic decAdd;
    logic decSub;
    logic highFix;

    assign decAdd = decimalFlag && (hold.aluOp == opAdd);
    assign decSub = decimalFlag && (hold.aluOp == opSub);

    // upper digit overflowed, either as a binary carry or past 99
    assign highFix = hold.acr || (hold.result > 8'h99);

    always_comb begin
        wbData   = hold.result;
        decCarry = hold.acr;
        if (decAdd) begin
            if ((hold.result[3:0] > 4'd9) || hold.hc)
                wbData = wbData + 8'h06;
            if (highFix)
                wbData = wbData + 8'h60;
            decCarry = highFix;
        end else if (decSub) begin
            // no half carry means the low digit borrowed
            if (!hold.hc)
                wbData = wbData - 8'h06;
            if (!hold.acr)
                wbData = wbData - 8'h60;
        end
    end

endmodule

/* src/statusReg.sv */
////////////////////////////////////////////////////////////////////////////
// processor status register, NV-BDIZC
// updates only for a valid held operation, using its flag mode
// a set bit wins over a clear bit for the same flag
// bit 4 reads 0 and bit 5 reads 1, also after a load
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module statusReg
    import cpuPkg::*;
(
    input  logic     phi2,
    input  logic     rstAll,
    input  holdReg_t hold,
    input  byte_t    wbData,
    input  logic     decCarry,
    output byte_t    status
);

    byte_t statusNext;
    byte_t loadValue;

    // loaded value with the fixed bits forced
    always_comb begin
        loadValue          = hold.data;
        loadValue[statusB] = 1'b0;
        loadValue          = loadValue | statusReset;
    end

    always_comb begin
        statusNext = status;
        case (hold.flagMode)
            flagNz, flagNzc, flagNzcv: begin
                statusNext[statusN] = wbData[dataWidth-1];
                statusNext[statusZ] = (wbData == '0);
                if (hold.flagMode != flagNz)
                    statusNext[statusC] = decCarry;
                if (hold.flagMode == flagNzcv)
                    statusNext[statusV] = hold.avr;
            end
            flagLoad:
                statusNext = loadValue;
            flagSetClr: begin
                if (hold.setClr.setC)
                    statusNext[statusC] = 1'b1;
                else if (hold.setClr.clrC)
                    statusNext[statusC] = 1'b0;
                if (hold.setClr.setI)
                    statusNext[statusI] = 1'b1;
                else if (hold.setClr.clrI)
                    statusNext[statusI] = 1'b0;
                if (hold.setClr.setD)
                    statusNext[statusD] = 1'b1;
                else if (hold.setClr.clrD)
                    statusNext[statusD] = 1'b0;
                if (hold.setClr.clrV)
                    statusNext[statusV] = 1'b0;
            end
            default: statusNext = status;
        endcase
    end

    always_ff @(posedge phi2 or posedge rstAll) begin
        if (rstAll)
            status <= statusReset;
        else if (hold.valid)
            status <= statusNext;
    end

endmodule

/* src/cpuDatapath.sv */
////////////////////////////////////////////////////////////////////////////
// two-stage 8-bit datapath, one control word per phi2 edge, no stall
// results and flags are visible one edge after the word is sampled
// an operation reading a register or C written by the word just before
// it sees the old value, so one bubble must separate them
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module cpuDatapath
    import cpuPkg::*;
(
    input  logic       phi2,
    input  logic       rstAll,
    input  ctrlWord_t  ctrl,
    input  byte_t      dataIn,
    output archState_t state
);

    byte_t    operandA;
    holdReg_t hold;
    byte_t    wbData;
    logic     decCarry;
    byte_t    status;
    regFile_t regs;

    registerFile u_registerFile (
        .phi2     (phi2),
        .rstAll   (rstAll),
        .aSel     (ctrl.aSel),
        .hold     (hold),
        .wbData   (wbData),
        .operandA (operandA),
        .regs     (regs)
    );

    aluStage u_aluStage (
        .phi2      (phi2),
        .rstAll    (rstAll),
        .ctrl      (ctrl),
        .operandA  (operandA),
        .dataIn    (dataIn),
        .carryFlag (status[statusC]),
        .hold      (hold)
    );

    decimalAdjust u_decimalAdjust (
        .hold        (hold),
        .decimalFlag (status[statusD]),
        .wbData      (wbData),
        .decCarry    (decCarry)
    );

    statusReg u_statusReg (
        .phi2     (phi2),
        .rstAll   (rstAll),
        .hold     (hold),
        .wbData   (wbData),
        .decCarry (decCarry),
        .status   (status)
    );

    assign state = {regs, status};

endmodule

/* verification/tbModel.svh */
////////////////////////////////////////////////////////////////////////////
// reference model of the datapath and the operation-issue task
// included inside tbCpuDatapath and uses its signals and its model state
// decimal results are defined for valid BCD operands only
// issue must be called 2 ns after a rising phi2 edge
////////////////////////////////////////////////////////////////////////////
`ifndef tbModelSvh
`define tbModelSvh

function automatic int bcdValue(byte_t v);
    return int'(v[7:4]) * 10 + int'(v[3:0]);
endfunction

function automatic byte_t toBcd(int v);
    byte_t r;
    r[7:4] = 4'(v / 10);
    r[3:0] = 4'(v % 10);
    return r;
endfunction

function automatic ctrlWord_t makeOp(aSrc_e a, bSrc_e b, cinSel_e ci, aluOp_e op,
                                     destMask_t dst, flagMode_e fm);
    ctrlWord_t c;
    c          = '0;
    c.valid    = 1'b1;
    c.aSel     = a;
    c.bSel     = b;
    c.cinSel   = ci;
    c.aluOp    = op;
    c.dest     = dst;
    c.flagMode = fm;
    return c;
endfunction

function automatic ctrlWord_t makeFlagOp(setClr_t sc);
    ctrlWord_t c;
    c        = makeOp(srcZero, bZero, cinZero, opAdd, noDest, flagSetClr);
    c.setClr = sc;
    return c;
endfunction

// state after one word has been committed
function automatic archState_t applyOp(archState_t s, ctrlWord_t c, byte_t d);
    archState_t n;
    byte_t      a;
    byte_t      b;
    byte_t      r;
    int         cin;
    int         full;
    int         sgn;
    logic       carry;
    logic       ovf;
    n     = s;
    r     = 8'h00;
    carry = 1'b0;
    ovf   = 1'b0;
    if (!c.valid)
        return s;
    case (c.aSel)
        srcAcc:  a = s.acc;
        srcX:    a = s.x;
        srcY:    a = s.y;
        srcSp:   a = s.sp;
        default: a = 8'h00;
    endcase
    b   = (c.bSel == bData) ? d : 8'h00;
    cin = (c.cinSel == cinOne) ? 1 : 0;
    if (c.cinSel == cinCarry)
        cin = int'(s.status[statusC]);
    case (c.aluOp)
        opAdd, opSub: begin
            // a clear carry-in means borrow on subtract
            if (c.aluOp == opAdd) begin
                full = int'(a) + int'(b) + cin;
                sgn  = int'($signed(a)) + int'($signed(b)) + cin;
            end else begin
                full = int'(a) - int'(b) - (1 - cin);
                sgn  = int'($signed(a)) - int'($signed(b)) - (1 - cin);
            end
            carry = (c.aluOp == opAdd) ? (full > 255) : (full >= 0);
            r     = full[7:0];
            ovf   = (sgn > 127) || (sgn < -128);
            if (s.status[statusD]) begin
                if (c.aluOp == opAdd)
                    full = bcdValue(a) + bcdValue(b) + cin;
                else
                    full = bcdValue(a) - bcdValue(b) - (1 - cin);
                carry = (c.aluOp == opAdd) ? (full > 99) : (full >= 0);
                r     = toBcd((full + 100) % 100);
            end
        end
        opAnd:   r = a & b;
        opEor:   r = a ^ b;
        opOr:    r = a | b;
        opShr: begin
            r     = {cin[0], b[7:1]};
            carry = b[0];
        end
        default: r = 8'h00;
    endcase
    if (c.dest.wrAcc)
        n.acc = r;
    if (c.dest.wrX)
        n.x = r;
    if (c.dest.wrY)
        n.y = r;
    if (c.dest.wrSp)
        n.sp = r;
    case (c.flagMode)
        flagNz, flagNzc, flagNzcv: begin
            n.status[statusN] = r[7];
            n.status[statusZ] = (r == 8'h00);
            if (c.flagMode != flagNz)
                n.status[statusC] = carry;
            if (c.flagMode == flagNzcv)
                n.status[statusV] = ovf;
        end
        flagLoad:   n.status = (d & 8'hef) | 8'h20;
        flagSetClr: begin
            n.status[statusC] = c.setClr.setC | (s.status[statusC] & ~c.setClr.clrC);
            n.status[statusI] = c.setClr.setI | (s.status[statusI] & ~c.setClr.clrI);
            n.status[statusD] = c.setClr.setD | (s.status[statusD] & ~c.setClr.clrD);
            n.status[statusV] = s.status[statusV] & ~c.setClr.clrV;
        end
        default: ;
    endcase
    return n;
endfunction

// issues one word and then a bubble that repeats its fields with valid clear
// the bubble must leave the committed state untouched
task automatic issue(input string name, input ctrlWord_t c, input byte_t d);
    archState_t expected;
    ctrlWord_t  bubble;
    bubble       = c;
    bubble.valid = 1'b0;
    expected     = applyOp(applyOp(model, c, d), bubble, d);
    ctrl         = c;
    dataIn       = d;
    waitEdge();
    ctrl = bubble;
    waitEdge();
    checkState(name, expected);
    model = expected;
endtask

`endif

/* verification/tbCpuDatapath.sv */
////////////////////////////////////////////////////////////////////////////
// testbench for the two-stage datapath
// inputs change 2 ns after a rising phi2 edge, state is checked there too
// each issued word is followed by a bubble except in the pipeline test
// the run stops at the first mismatch or when the clock stops
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module tbCpuDatapath
    import cpuPkg::*;
();

    localparam destMask_t toAcc     = 4'b1000;
    localparam destMask_t toX       = 4'b0100;
    localparam destMask_t toY       = 4'b0010;
    localparam destMask_t toSp      = 4'b0001;
    localparam destMask_t noDest    = 4'b0000;
    localparam int        edgeLimit = 60;
    localparam aluOp_e    logicOps [4] = '{opAnd, opEor, opOr, opShr};

    logic       phi2;
    logic       rstAll;
    ctrlWord_t  ctrl;
    byte_t      dataIn;
    archState_t state;
    archState_t model;

    cpuDatapath u_cpuDatapath (
        .phi2   (phi2),
        .rstAll (rstAll),
        .ctrl   (ctrl),
        .dataIn (dataIn),
        .state  (state)
    );

    `include "tbModel.svh"

    initial begin
        phi2 = 1'b0;
        forever begin
            #10 phi2 = ~phi2;
        end
    end

    // polls off the 1 ns clock grid and returns 2 ns after the rising edge
    task automatic waitEdge();
        int guard;
        guard = 0;
        #0.5;
        while (phi2 !== 1'b0 && guard < edgeLimit) begin
            #1;
            guard++;
        end
        while (phi2 !== 1'b1 && guard < edgeLimit) begin
            #1;
            guard++;
        end
        if (guard >= edgeLimit) begin
            $display("timeout: no rising phi2 edge within %0d ns", edgeLimit);
            $display("Testbench failed");
            $fatal(1, "clock stopped");
        end else begin
            #1.5;
        end
    endtask

    function automatic byte_t randByte();
        int unsigned v;
        v = $urandom;
        return v[7:0];
    endfunction

    task automatic checkState(input string name, input archState_t expected);
        assert (state === expected)
        else begin
            $display("[ERROR] %s expected %h actual %h", name, expected, state);
            $display("Testbench failed");
            $fatal(1, "state mismatch");
        end
    endtask

    initial begin
        int         k;
        byte_t      opA;
        byte_t      opB;
        ctrlWord_t  c1;
        ctrlWord_t  c2;
        archState_t firstExp;
        archState_t secondExp;
        void'($urandom(32'hf8c7021e));
        rstAll = 1'b1;
        ctrl   = '0;
        dataIn = '0;
        for (k = 0; k < 16; k++)
            waitEdge();
        rstAll = 1'b0;
        model  = '{acc: 8'h00, x: 8'h00, y: 8'h00, sp: 8'h00, status: 8'h20};
        checkState("reset", model);

        // binary add and subtract, D is clear out of reset
        for (k = 0; k < 40; k++) begin
            issue("loadAcc", makeOp(srcZero, bData, cinZero, opAdd, toAcc, flagNz), randByte());
            issue(k[0] ? "binSub" : "binAdd",
                  makeOp(srcAcc, bData, cinCarry, k[0] ? opSub : opAdd, toAcc, flagNzcv),
                  randByte());
        end

        for (k = 0; k < 24; k++) begin
            issue("loadX", makeOp(srcZero, bData, cinZero, opAdd, toX, flagNz), randByte());
            issue("logicOp", makeOp(srcX, bData, cinCarry, logicOps[k[1:0]],
                  k[2] ? toY : toX, k[3] ? flagNzc : flagNz), randByte());
        end

        // setD is bit 2 of the set/clear field
        issue("setD", makeFlagOp(7'b0000100), 8'h00);
        for (k = 0; k < 20; k++) begin
            issue("loadBcd", makeOp(srcZero, bData, cinZero, opAdd, toAcc, flagNz),
                  toBcd($urandom_range(99)));
            issue(k[0] ? "bcdSub" : "bcdAdd",
                  makeOp(srcAcc, bData, cinCarry, k[0] ? opSub : opAdd, toAcc, flagNzc),
                  toBcd($urandom_range(99)));
        end

        for (k = 0; k < 8; k++)
            issue("flagLoad", makeOp(srcZero, bZero, cinZero, opAdd, noDest, flagLoad),
                  randByte());
        for (k = 0; k < 12; k++) begin
            opA = randByte();
            issue("setClr", makeFlagOp(opA[6:0]), 8'h00);
        end
        issue("clrD", makeFlagOp(7'b0000010), 8'h00);

        // two independent words back to back, results one edge apart
        opA       = randByte();
        opB       = randByte();
        c1        = makeOp(srcZero, bData, cinZero, opAdd, toY, flagNz);
        c2        = makeOp(srcAcc, bData, cinZero, opEor, toSp, flagNz);
        firstExp  = applyOp(model, c1, opA);
        secondExp = applyOp(firstExp, c2, opB);
        ctrl      = c1;
        dataIn    = opA;
        waitEdge();
        ctrl   = c2;
        dataIn = opB;
        waitEdge();
        ctrl = '0;
        checkState("pipeFirst", firstExp);
        waitEdge();
        checkState("pipeSecond", secondExp);
        model = secondExp;

        $display("Testbench passed");
        $finish;
    end

endmodule

/* vlog.f */
+incdir+verification
src/cpuPkg.sv
src/registerFile.sv
src/aluStage.sv
src/decimalAdjust.sv
src/statusReg.sv
src/cpuDatapath.sv
verification/tbCpuDatapath.sv

/* run.sh */
#!/bin/sh
# compile and run the datapath testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --assert --timescale 1ns/10ps --top-module tbCpuDatapath \
    -Mdir obj_dir -f vlog.f
output=$(./obj_dir/VtbCpuDatapath || true)
printf '%s\n' "$output"
if printf '%s\n' "$output" | grep -qx "Testbench passed"; then
    exit 0
else
    echo "simulation did not pass"
    exit 1
fi
